/* common/gb_cart_pkg.sv */
/*
 * shared types, widths and header decode tables for the cartridge block
 * every cartridge module pulls this in with a wildcard import
 */
package gb_cart_pkg;

	// ------------------------------------------------------------------------
	// widths
	// ------------------------------------------------------------------------
	localparam int CART_ADDR_W = 16;
	localparam int ROM_BANK_W  = 9;	// 512 banks of 16 KB
	localparam int ROM_ADDR_W  = 23;	// byte address into the ROM image
	localparam int RAM_BANK_W  = 4;
	localparam int CRAM_ADDR_W = 17;	// 128 KB cartridge RAM
	localparam int DL_ADDR_W   = 25;
	localparam int DL_DATA_W   = 16;

	// header words, as even download byte addresses
	localparam logic [DL_ADDR_W-1:0] HDR_TYPE_ADDR = 25'h000146;
	localparam logic [DL_ADDR_W-1:0] HDR_SIZE_ADDR = 25'h000148;

	typedef enum logic [2:0] {
		MBC_NONE,
		MBC1,
		MBC2,
		MBC3,
		MBC5
	} mbc_kind_t;

	// cpu address bits 15..13
	typedef enum logic [2:0] {
		REG_RAM_EN   = 3'd0,
		REG_ROM_BANK = 3'd1,
		REG_RAM_BANK = 3'd2,
		REG_MODE     = 3'd3,
		REG_CRAM     = 3'd5
	} cart_region_t;

	typedef enum logic [1:0] {
		SRC_OPEN,	// ram disabled, bus floats high
		SRC_BYTE,
		SRC_NIBBLE,	// mbc2 internal 4 bit ram
		SRC_RTC
	} ram_src_t;

	typedef enum logic [2:0] {
		RTC_SEC,
		RTC_MIN,
		RTC_HOUR,
		RTC_DAY_LO,
		RTC_DAY_HI
	} rtc_reg_t;

	// ------------------------------------------------------------------------
	// header tables
	// ------------------------------------------------------------------------
	function automatic logic [ROM_BANK_W-1:0] rom_mask_of(input logic [7:0] code);
		case (code)
			8'h00:   return 9'h001;	// 32 KB, direct mapped
			8'h01:   return 9'h003;
			8'h02:   return 9'h007;
			8'h03:   return 9'h00F;
			8'h04:   return 9'h01F;
			8'h05:   return 9'h03F;
			8'h06:   return 9'h07F;
			8'h07:   return 9'h0FF;
			8'h08:   return 9'h1FF;	// 8 MB
			default: return 9'h07F;	// 0x52..0x54 odd sizes land here too
		endcase
	endfunction

	function automatic logic [RAM_BANK_W-1:0] ram_mask_of(input logic [7:0] code);
		case (code)
			8'h00, 8'h01, 8'h02: return 4'h0;	// a single 8 KB bank at most
			8'h03:               return 4'h3;
			default:             return 4'hF;
		endcase
	endfunction

	function automatic mbc_kind_t mbc_kind_of(input logic [7:0] cart_type);
		case (cart_type) inside
			[8'h01:8'h03]: return MBC1;
			[8'h05:8'h06]: return MBC2;
			[8'h0F:8'h13]: return MBC3;
			[8'h19:8'h1E]: return MBC5;
			default:       return MBC_NONE;
		endcase
	endfunction

endpackage

/* verilog/cart_header.sv */
/*
 * snoops the rom download for the cartridge type and size codes,
 * then decodes mapper kind and bank masks from them
 */
`timescale 1ns/1ps

module cart_header
	import gb_cart_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  dl_wr,
	input  logic [DL_ADDR_W-1:0]  dl_addr,
	input  logic [DL_DATA_W-1:0]  dl_data,
	output mbc_kind_t             mbc_kind,
	output logic [ROM_BANK_W-1:0] rom_mask,
	output logic [RAM_BANK_W-1:0] ram_mask
);

	logic [7:0] cart_type;
	logic [7:0] rom_size;
	logic [7:0] ram_size;

	// ------------------------------------------------------------------------
	// capture
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_type <= 8'h00;	// reads back as a plain rom cart
			rom_size  <= 8'h00;
			ram_size  <= 8'h00;
		end else if (dl_wr) begin
			if (dl_addr == HDR_TYPE_ADDR) begin
				cart_type <= dl_data[15:8];	// low byte is the sgb flag
			end
			if (dl_addr == HDR_SIZE_ADDR) begin
				rom_size <= dl_data[7:0];
				ram_size <= dl_data[15:8];
			end
		end
	end

	// ------------------------------------------------------------------------
	// decode
	// ------------------------------------------------------------------------
	always_comb begin
		mbc_kind = mbc_kind_of(cart_type);
		rom_mask = rom_mask_of(rom_size);
		ram_mask = ram_mask_of(ram_size);
	end

endmodule

/* mbc/mbc_ctrl.sv */
/*
 * cpu side register file of the mapper: decodes writes by region into the
 * bank, mode and enable registers and turns A000-BFFF accesses into strobes
 */
`timescale 1ns/1ps

module mbc_ctrl
	import gb_cart_pkg::*;
(
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   cart_wr,
	input  logic                   cart_rd,
	input  logic [CART_ADDR_W-1:0] cart_addr,
	input  logic [7:0]             cart_di,
	input  mbc_kind_t              mbc_kind,
	output logic [ROM_BANK_W-1:0]  rom_bank_reg,
	output logic [RAM_BANK_W-1:0]  ram_bank_reg,
	output logic                   mbc1_mode,
	output rtc_reg_t               rtc_index,
	output logic                   ram_wr,
	output logic                   ram_rd,
	output ram_src_t               ram_src,
	output logic                   rtc_wr
);

	cart_region_t region;
	logic         cram_hit;
	logic         ram_enable;
	logic         rtc_mode;	// mbc3 maps the clock over the ram window
	logic         bank_is_one;

	assign region   = cart_region_t'(cart_addr[15:13]);
	assign cram_hit = (region == REG_CRAM);

	// writing bank 0 selects bank 1 on the older mappers
	assign bank_is_one = (cart_di[6:0] == 7'd0) ||
		(mbc_kind == MBC1 && cart_di[4:0] == 5'd0) ||
		(mbc_kind == MBC2 && cart_di[3:0] == 4'd0);

	// ------------------------------------------------------------------------
	// register writes
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_bank_reg <= 9'd1;
			ram_bank_reg <= 4'd0;
			mbc1_mode    <= 1'b0;
			rtc_mode     <= 1'b0;
			rtc_index    <= RTC_SEC;
			ram_enable   <= 1'b0;
		end else if (cart_wr) begin
			case (region)
				REG_RAM_EN: ram_enable <= (cart_di[3:0] == 4'hA);
				REG_ROM_BANK: begin
					if (mbc_kind == MBC5) begin
						if (cart_addr[12]) begin
							rom_bank_reg[8] <= cart_di[0];	// 3000-3FFF high bit
						end else begin
							rom_bank_reg[7:0] <= cart_di;
						end
					end else if (bank_is_one) begin
						rom_bank_reg <= 9'd1;
					end else begin
						rom_bank_reg <= {2'b00, cart_di[6:0]};
					end
				end
				REG_RAM_BANK: begin
					if (mbc_kind == MBC3) begin
						rtc_mode <= cart_di[3];
						if (cart_di[3]) begin
							rtc_index <= rtc_reg_t'(cart_di[2:0]);
						end else begin
							ram_bank_reg <= {2'b00, cart_di[1:0]};
						end
					end else if (mbc_kind == MBC5) begin
						ram_bank_reg <= cart_di[3:0];
					end else begin
						ram_bank_reg <= {2'b00, cart_di[1:0]};
					end
				end
				REG_MODE: begin
					if (mbc_kind == MBC1) begin
						mbc1_mode <= cart_di[0];
					end
				end
				default: ;	// cram writes go out as strobes below
			endcase
		end
	end

	// ------------------------------------------------------------------------
	// ram window strobes
	// ------------------------------------------------------------------------
	assign rtc_wr = cart_wr && cram_hit && rtc_mode;
	assign ram_wr = cart_wr && cram_hit && ram_enable;
	assign ram_rd = cart_rd && cram_hit;

	always_comb begin
		if (!ram_enable) begin
			ram_src = SRC_OPEN;
		end else if (rtc_mode) begin
			ram_src = SRC_RTC;
		end else if (mbc_kind == MBC2) begin
			ram_src = SRC_NIBBLE;
		end else begin
			ram_src = SRC_BYTE;
		end
	end

endmodule

/* mbc/mbc_map.sv */
/*
 * combinational banking: turns the cpu address and the mapper registers
 * into a rom byte address and a cartridge ram address
 */
`timescale 1ns/1ps

module mbc_map
	import gb_cart_pkg::*;
(
	input  logic [CART_ADDR_W-1:0] cart_addr,
	input  mbc_kind_t              mbc_kind,
	input  logic [ROM_BANK_W-1:0]  rom_mask,
	input  logic [RAM_BANK_W-1:0]  ram_mask,
	input  logic [ROM_BANK_W-1:0]  rom_bank_reg,
	input  logic [RAM_BANK_W-1:0]  ram_bank_reg,
	input  logic                   mbc1_mode,
	output logic [ROM_ADDR_W-1:0]  rom_addr,
	output logic [CRAM_ADDR_W-1:0] cram_addr
);

	logic [ROM_BANK_W-1:0] base_bank;
	logic [1:0]            bank2;
	logic [ROM_BANK_W-1:0] rom_bank;
	logic [RAM_BANK_W-1:0] ram_bank;

	// 0000-3FFF always sees bank 0 unless mbc1 mode 1 moves it
	assign base_bank = (cart_addr[15:14] == 2'b00) ? 9'd0 : rom_bank_reg;

	// mbc1 upper bits only reach 0000-3FFF and the ram in mode 1
	assign bank2 = ram_bank_reg[1:0] & {2{cart_addr[14] | mbc1_mode}};

	always_comb begin
		rom_bank = {8'd0, cart_addr[14]};	// no mapper, flat 32 KB
		ram_bank = 4'd0;
		case (mbc_kind)
			MBC1: begin
				rom_bank = {2'b00, bank2, base_bank[4:0]} & rom_mask;
				ram_bank = {2'b00, bank2} & ram_mask;
			end
			MBC2: begin
				rom_bank = {2'b00, base_bank[6:0]} & rom_mask;
			end
			MBC3: begin
				rom_bank = {2'b00, base_bank[6:0]} & rom_mask;
				ram_bank = ram_bank_reg & ram_mask;
			end
			MBC5: begin
				rom_bank = base_bank & rom_mask;
				ram_bank = ram_bank_reg & ram_mask;
			end
			default: ;
		endcase
	end

	assign rom_addr  = {rom_bank, cart_addr[13:0]};
	assign cram_addr = {ram_bank, cart_addr[12:0]};	// 8 KB window

endmodule

/* rtc/mbc3_rtc.sv */
/*
 * mbc3 real-time clock, counting on an external one second strobe;
 * the game can write every register and read the selected one back
 */
`timescale 1ns/1ps

module mbc3_rtc
	import gb_cart_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       rtc_tick,
	input  logic       rtc_wr,
	input  rtc_reg_t   rtc_index,
	input  logic [7:0] cart_di,
	output logic [7:0] rtc_q
);

	logic [5:0] seconds;
	logic [5:0] minutes;
	logic [4:0] hours;
	logic [8:0] days;
	logic       halt;
	logic       overflow;

	logic sec_wrap;
	logic min_wrap;
	logic hour_wrap;

	// carry chain, all resolved in the tick cycle
	assign sec_wrap  = (seconds == 6'd59);
	assign min_wrap  = sec_wrap && (minutes == 6'd59);
	assign hour_wrap = min_wrap && (hours == 5'd23);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			seconds  <= 6'd0;
			minutes  <= 6'd0;
			hours    <= 5'd0;
			days     <= 9'd0;
			halt     <= 1'b0;
			overflow <= 1'b0;
		end else if (rtc_wr) begin	// game write beats a tick
			case (rtc_index)
				RTC_SEC:    seconds   <= cart_di[5:0];
				RTC_MIN:    minutes   <= cart_di[5:0];
				RTC_HOUR:   hours     <= cart_di[4:0];
				RTC_DAY_LO: days[7:0] <= cart_di;
				RTC_DAY_HI: begin
					days[8]  <= cart_di[0];
					halt     <= cart_di[6];
					overflow <= cart_di[7];
				end
				default: ;
			endcase
		end else if (rtc_tick && !halt) begin
			seconds <= sec_wrap ? 6'd0 : seconds + 6'd1;
			if (sec_wrap) begin
				minutes <= (minutes == 6'd59) ? 6'd0 : minutes + 6'd1;
			end
			if (min_wrap) begin
				hours <= (hours == 5'd23) ? 5'd0 : hours + 5'd1;
			end
			if (hour_wrap) begin
				days <= days + 9'd1;	// 511 rolls to 0 by itself
				if (days == 9'd511) begin
					overflow <= 1'b1;
				end
			end
		end
	end

	// ------------------------------------------------------------------------
	// readback
	// ------------------------------------------------------------------------
	always_comb begin
		case (rtc_index)
			RTC_SEC:    rtc_q = {2'b00, seconds};
			RTC_MIN:    rtc_q = {2'b00, minutes};
			RTC_HOUR:   rtc_q = {3'b000, hours};
			RTC_DAY_LO: rtc_q = days[7:0];
			RTC_DAY_HI: rtc_q = {overflow, halt, 5'b00000, days[8]};
			default:    rtc_q = 8'hFF;
		endcase
	end

endmodule

/* verilog/cart_ram.sv */
/*
 * 128 KB cartridge ram with a registered read port; the data phase
 * picks ram byte, mbc2 nibble, clock register or open bus
 */
`timescale 1ns/1ps

module cart_ram
	import gb_cart_pkg::*;
(
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   ram_wr,
	input  logic                   ram_rd,
	input  ram_src_t               ram_src,
	input  logic [CRAM_ADDR_W-1:0] cram_addr,
	input  logic [7:0]             cart_di,
	input  logic [7:0]             rtc_q,
	output logic [7:0]             cart_do,
	output logic                   rd_valid
);

	logic [7:0] mem [0:(1 << CRAM_ADDR_W)-1];
	logic [7:0] ram_q;
	ram_src_t   src_q;	// source of the read in its data phase

	always_ff @(posedge clk_sys) begin
		if (ram_wr) begin
			mem[cram_addr] <= cart_di;
		end
		if (ram_rd) begin
			ram_q <= mem[cram_addr];
			src_q <= ram_src;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= ram_rd;	// one data phase per read, back to back allowed
		end
	end

	always_comb begin
		case (src_q)
			SRC_BYTE:   cart_do = ram_q;
			SRC_NIBBLE: cart_do = {4'hF, ram_q[3:0]};
			SRC_RTC:    cart_do = rtc_q;
			default:    cart_do = 8'hFF;	// ram disabled
		endcase
	end

endmodule

/* verilog/gb_cart.sv */
/*
 * cartridge side of the console: header capture, mapper registers,
 * address mapping, cartridge RAM and the mbc3 clock
 */
`timescale 1ns/1ps

module gb_cart
	import gb_cart_pkg::*;
(
	input  logic                   clk_sys,
	input  logic                   reset,

	// rom image download
	input  logic                   dl_wr,
	input  logic [DL_ADDR_W-1:0]   dl_addr,
	input  logic [DL_DATA_W-1:0]   dl_data,

	// cpu side
	input  logic                   cart_wr,
	input  logic                   cart_rd,
	input  logic [CART_ADDR_W-1:0] cart_addr,
	input  logic [7:0]             cart_di,

	input  logic                   rtc_tick,	// one pulse per second

	output logic [ROM_ADDR_W-1:0]  rom_addr,
	output logic [7:0]             cart_do,
	output logic                   rd_valid
);

	mbc_kind_t              mbc_kind;
	logic [ROM_BANK_W-1:0]  rom_mask;
	logic [RAM_BANK_W-1:0]  ram_mask;
	logic [ROM_BANK_W-1:0]  rom_bank_reg;
	logic [RAM_BANK_W-1:0]  ram_bank_reg;
	logic                   mbc1_mode;
	rtc_reg_t               rtc_index;
	logic                   ram_wr;
	logic                   ram_rd;
	ram_src_t               ram_src;
	logic                   rtc_wr;
	logic [CRAM_ADDR_W-1:0] cram_addr;
	logic [7:0]             rtc_q;

	cart_header cart_header_inst (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.dl_wr    (dl_wr),
		.dl_addr  (dl_addr),
		.dl_data  (dl_data),
		.mbc_kind (mbc_kind),
		.rom_mask (rom_mask),
		.ram_mask (ram_mask)
	);

	mbc_ctrl mbc_ctrl_inst (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.cart_wr      (cart_wr),
		.cart_rd      (cart_rd),
		.cart_addr    (cart_addr),
		.cart_di      (cart_di),
		.mbc_kind     (mbc_kind),
		.rom_bank_reg (rom_bank_reg),
		.ram_bank_reg (ram_bank_reg),
		.mbc1_mode    (mbc1_mode),
		.rtc_index    (rtc_index),
		.ram_wr       (ram_wr),
		.ram_rd       (ram_rd),
		.ram_src      (ram_src),
		.rtc_wr       (rtc_wr)
	);

	mbc_map mbc_map_inst (
		.cart_addr    (cart_addr),
		.mbc_kind     (mbc_kind),
		.rom_mask     (rom_mask),
		.ram_mask     (ram_mask),
		.rom_bank_reg (rom_bank_reg),
		.ram_bank_reg (ram_bank_reg),
		.mbc1_mode    (mbc1_mode),
		.rom_addr     (rom_addr),
		.cram_addr    (cram_addr)
	);

	mbc3_rtc mbc3_rtc_inst (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.rtc_tick  (rtc_tick),
		.rtc_wr    (rtc_wr),
		.rtc_index (rtc_index),
		.cart_di   (cart_di),
		.rtc_q     (rtc_q)
	);

	cart_ram cart_ram_inst (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.ram_wr    (ram_wr),
		.ram_rd    (ram_rd),
		.ram_src   (ram_src),
		.cram_addr (cram_addr),
		.cart_di   (cart_di),
		.rtc_q     (rtc_q),
		.cart_do   (cart_do),
		.rd_valid  (rd_valid)
	);

endmodule

/* tb/gb_cart_props.sv */
/*
 * concurrent checks on the cartridge read path and the fixed bank 0 window,
 * bound into gb_cart
 */
`timescale 1ns/1ps

module gb_cart_props
	import gb_cart_pkg::*;
(
	input logic                   clk_sys,
	input logic                   reset,
	input logic                   cart_rd,
	input logic [CART_ADDR_W-1:0] cart_addr,
	input mbc_kind_t              mbc_kind,
	input logic [ROM_ADDR_W-1:0]  rom_addr,
	input logic                   rd_valid
);

	logic cram_read;

	assign cram_read = cart_rd && (cart_addr[15:13] == REG_CRAM);

	a_read_returns: assert property (@(posedge clk_sys) disable iff (reset)
		cram_read |=> rd_valid)
		else $error("ram window read gave no rd_valid on the next cycle");

	a_no_orphan: assert property (@(posedge clk_sys) disable iff (reset)
		!cart_rd |=> !rd_valid)
		else $error("rd_valid without a read in the cycle before");

	a_reset_clears: assert property (@(posedge clk_sys) reset |=> !rd_valid)
		else $error("rd_valid high right after reset");

	// only mbc1 mode 1 may move 0000-3FFF away from bank 0
	a_bank0: assert property (@(posedge clk_sys) disable iff (reset)
		(mbc_kind != MBC1 && cart_addr[15:14] == 2'b00) |-> rom_addr[22:14] == 9'd0)
		else $error("low rom window not on bank 0");

endmodule

bind gb_cart gb_cart_props gb_cart_props_inst (
	.clk_sys   (clk_sys),
	.reset     (reset),
	.cart_rd   (cart_rd),
	.cart_addr (cart_addr),
	.mbc_kind  (mbc_kind),
	.rom_addr  (rom_addr),
	.rd_valid  (rd_valid)
);

/* tb/gb_cart_tb.sv */
/*
 * testbench for gb_cart: replays the operations in tb/gb_cart_vectors.txt
 * and checks rom address, read data and read latency against them
 */
`timescale 1ns/1ps

module gb_cart_tb
	import gb_cart_pkg::*;
();

	logic                   clk_sys;
	logic                   reset;
	logic                   dl_wr;
	logic [DL_ADDR_W-1:0]   dl_addr;
	logic [DL_DATA_W-1:0]   dl_data;
	logic                   cart_wr;
	logic                   cart_rd;
	logic [CART_ADDR_W-1:0] cart_addr;
	logic [7:0]             cart_di;
	logic                   rtc_tick;
	logic [ROM_ADDR_W-1:0]  rom_addr;
	logic [7:0]             cart_do;
	logic                   rd_valid;

	logic [31:0]   lcg_state;
	logic [7:0]    model [0:15][0:31];	// last byte written per bank and slot
	int            error_count;
	int            line_no;
	int            fd;
	int            scan_code;
	logic [1023:0] line;
	logic [31:0]   f_test;
	logic [31:0]   f_op;
	logic [31:0]   f_a;
	logic [31:0]   f_b;
	logic [31:0]   f_c;

	gb_cart gb_cart_inst (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.dl_wr     (dl_wr),
		.dl_addr   (dl_addr),
		.dl_data   (dl_data),
		.cart_wr   (cart_wr),
		.cart_rd   (cart_rd),
		.cart_addr (cart_addr),
		.cart_di   (cart_di),
		.rtc_tick  (rtc_tick),
		.rom_addr  (rom_addr),
		.cart_do   (cart_do),
		.rd_valid  (rd_valid)
	);

	always #50 clk_sys = ~clk_sys;	// 100 ns period

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// spread the slots of one bank over the 8 KB window
	function automatic logic [15:0] window_addr(input int slot);
		logic [12:0] off;
		off = 13'(slot * 131);
		return {3'b101, off};
	endfunction

	// ------------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------------
	task automatic stop_run();
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			error_count++;
			$display("ERR %s expected %h actual %h", name, expected, actual);
			stop_run();
		end
	endtask

	// ------------------------------------------------------------------------
	// bus operations, each starts and ends just after a falling edge
	// ------------------------------------------------------------------------
	task automatic write_header(input logic [DL_ADDR_W-1:0] addr, input logic [15:0] data);
		dl_addr = addr;
		dl_data = data;
		dl_wr   = 1'b1;
		@(negedge clk_sys);
		dl_wr = 1'b0;
	endtask

	task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
		cart_addr = addr;
		cart_di   = data;
		cart_wr   = 1'b1;
		@(negedge clk_sys);
		cart_wr = 1'b0;
	endtask

	task automatic cpu_read(input string name, input logic [15:0] addr,
		output logic [7:0] data);
		int waited;
		cart_addr = addr;
		cart_rd   = 1'b1;
		@(negedge clk_sys);
		cart_rd = 1'b0;
		waited  = 1;
		while (!rd_valid && waited < 16) begin
			@(negedge clk_sys);
			waited++;
		end
		if (!rd_valid) begin
			$display("timeout: no read data for %s after %0d cycles", name, waited);
			stop_run();
		end
		check_value({name, " latency"}, 32'd1, waited);
		data = cart_do;
	endtask

	task automatic check_rom(input string name, input logic [15:0] addr,
		input logic [31:0] expected);
		cart_addr = addr;
		#25;	// middle of the low phase, mapping has settled
		check_value(name, expected, {9'd0, rom_addr});
		@(negedge clk_sys);
	endtask

	task automatic pulse_ticks(input logic [31:0] count);
		for (int k = 0; k < count; k++) begin
			rtc_tick = 1'b1;
			@(negedge clk_sys);
			rtc_tick = 1'b0;
			@(negedge clk_sys);
		end
	endtask

	task automatic apply_reset(input logic [31:0] cycles);
		reset = 1'b1;
		repeat (cycles) @(negedge clk_sys);
		reset = 1'b0;
	endtask

	task automatic fill_bank(input logic [3:0] bank, input logic [31:0] count);
		cpu_write(16'h4000, {4'h0, bank});
		for (int i = 0; i < count && i < 32; i++) begin
			lcg_state = lcg_next(lcg_state);
			model[bank][i[4:0]] = lcg_state[23:16];
			cpu_write(window_addr(i), lcg_state[23:16]);
		end
	endtask

	task automatic verify_bank(input string name, input logic [3:0] bank,
		input logic [31:0] count, input logic nibble);
		logic [7:0] expected;
		logic [7:0] data;
		cpu_write(16'h4000, {4'h0, bank});
		for (int i = 0; i < count && i < 32; i++) begin
			expected = model[bank][i[4:0]];
			if (nibble) begin
				expected = {4'hF, expected[3:0]};	// mbc2 upper nibble floats
			end
			cpu_read($sformatf("%s slot %0d", name, i), window_addr(i), data);
			check_value($sformatf("%s slot %0d", name, i), {24'd0, expected}, {24'd0, data});
		end
	endtask

	task automatic run_line(input string name, input logic [31:0] op, input logic [31:0] a,
		input logic [31:0] b, input logic [31:0] c);
		logic [7:0] data;
		case (op)
			32'd1: write_header(a[DL_ADDR_W-1:0], b[15:0]);
			32'd2: cpu_write(a[15:0], b[7:0]);
			32'd3: begin
				cpu_read(name, a[15:0], data);
				check_value(name, b, {24'd0, data});
			end
			32'd4: check_rom(name, a[15:0], b);
			32'd5: pulse_ticks(a);
			32'd6: apply_reset(a);
			32'd7: fill_bank(a[3:0], b);
			32'd8: verify_bank(name, a[3:0], b, c[0]);
			default: begin
				$display("unknown operation %0d in the vector file at %s", op, name);
				stop_run();
			end
		endcase
	endtask

	// ------------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------------
	initial begin
		clk_sys     = 1'b0;
		reset       = 1'b1;
		dl_wr       = 1'b0;
		dl_addr     = '0;
		dl_data     = '0;
		cart_wr     = 1'b0;
		cart_rd     = 1'b0;
		cart_addr   = '0;
		cart_di     = '0;
		rtc_tick    = 1'b0;
		error_count = 0;
		line_no     = 0;
		lcg_state   = 32'd39;
		repeat (5) @(negedge clk_sys);
		reset = 1'b0;

		fd = $fopen("tb/gb_cart_vectors.txt", "r");
		if (fd == 0) begin
			$display("cannot open the vector file tb/gb_cart_vectors.txt");
			stop_run();
		end
		while (!$feof(fd) && line_no < 1000) begin
			line      = '0;
			scan_code = $fgets(line, fd);
			line_no++;
			scan_code = $sscanf(line, "%h %h %h %h %h", f_test, f_op, f_a, f_b, f_c);
			if (scan_code == 5) begin	// comment and blank lines fall through
				run_line($sformatf("test %0d line %0d", f_test, line_no), f_op, f_a, f_b, f_c);
			end
		end
		$fclose(fd);

		if (error_count == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* tb/gb_cart_vectors.txt */
# columns, all hex: test op a b c; op 1 header a=dl addr b=word, 2 write a=addr b=data,
# 3 read a=addr b=expected, 4 rom a=addr b=expected, 5 ticks a=n, 6 reset a=cycles,
# 7 fill a=ram bank b=count, 8 verify a=ram bank b=count c=nibble
1 4 3fff 003fff 0   no mapper, flat rom
1 4 4000 004000 0
1 4 7abc 007abc 0
1 3 a000 ff 0       ram still disabled
2 1 146 0100 0      mbc1
2 1 148 0306 0      128 banks, 4 ram banks
2 2 2000 20 0       low five bits zero selects bank 1
2 4 4123 004123 0
2 2 2000 45 0
2 4 4123 014123 0
2 2 4000 02 0       upper bank bits
2 4 4123 114123 0
2 4 0123 000123 0   mode 0 keeps bank 0 low
2 2 6000 01 0
2 4 0123 100123 0   mode 1 moves the low window
2 1 148 0302 0      8 banks
2 4 4123 014123 0
3 6 3 0 0
3 1 146 1900 0      mbc5
3 1 148 0008 0      512 banks
3 2 2000 34 0
3 2 3000 01 0
3 4 4010 4d0010 0
3 1 148 0005 0      64 banks
3 4 4010 0d0010 0
3 2 2000 00 0
3 2 3000 00 0
3 4 4010 000010 0   bank 0 stays 0
4 6 3 0 0
4 1 146 1b00 0      mbc5 with ram
4 1 148 0405 0      16 ram banks
4 3 a000 ff 0
4 2 0000 0a 0
4 7 0 20 0
4 7 9 20 0
4 8 0 20 0
4 8 9 20 0
4 2 0000 00 0       disable
4 3 a000 ff 0
4 2 0000 1a 0       low nibble a enables
4 1 146 0500 0      mbc2
4 7 0 10 0
4 8 0 10 1
5 6 3 0 0
5 1 146 1000 0      mbc3
5 2 0000 0a 0
5 2 4000 08 0       seconds
5 2 a000 3b 0
5 2 4000 09 0       minutes
5 2 a000 3b 0
5 2 4000 0a 0       hours
5 2 a000 17 0
5 2 4000 0b 0       day low
5 2 a000 ff 0
5 2 4000 0c 0       day high
5 2 a000 01 0
5 5 1 0 0
5 3 a000 80 0       days wrapped, overflow set
5 2 4000 08 0
5 3 a000 00 0
5 2 4000 0a 0
5 3 a000 00 0
5 2 4000 0b 0
5 3 a000 00 0
5 2 4000 0c 0
5 2 a000 40 0       halt
5 5 3 0 0
5 3 a000 40 0
5 2 4000 08 0
5 3 a000 00 0       halted clock holds

/* compile.f */
common/gb_cart_pkg.sv
verilog/cart_header.sv
mbc/mbc_ctrl.sv
mbc/mbc_map.sv
rtc/mbc3_rtc.sv
verilog/cart_ram.sv
verilog/gb_cart.sv
tb/gb_cart_props.sv
tb/gb_cart_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the cartridge testbench with verilator and runs it from the project root
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f compile.f --top-module gb_cart_tb -o gb_cart_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/gb_cart_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "RESULT: PASS" "$log"; then
	exit 0
fi
echo "pass line not found in $log"
exit 1
